// ==== src/csr_pkg.sv ====
/* Shared types and constants for the machine-mode CSR unit. RV32 only, no supervisor mode.
   FS, VS and XS are fixed at off, so mstatus keeps those bits at zero. */
package csr_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  localparam logic [XLEN-1:0] HART_ID    = 32'h0000_0000;
  localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_0100;  // MXL=1, I and U
  localparam logic [XLEN-1:0] IRQ_MASK   = 32'h0000_0888;  // msi, mti, mei only

  // Machine trap setup and handling
  localparam logic [CSR_ADDR_W-1:0] MSTATUS_ADDR       = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] MISA_ADDR          = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] MIE_ADDR           = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] MTVEC_ADDR         = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] MCOUNTEREN_ADDR    = 12'h306;
  localparam logic [CSR_ADDR_W-1:0] MCOUNTINHIBIT_ADDR = 12'h320;
  localparam logic [CSR_ADDR_W-1:0] MSCRATCH_ADDR      = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] MEPC_ADDR          = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] MCAUSE_ADDR        = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] MTVAL_ADDR         = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] MIP_ADDR           = 12'h344;
  // Counters, machine and user views
  localparam logic [CSR_ADDR_W-1:0] MCYCLE_ADDR        = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] MINSTRET_ADDR      = 12'hB02;
  localparam logic [CSR_ADDR_W-1:0] MCYCLEH_ADDR       = 12'hB80;
  localparam logic [CSR_ADDR_W-1:0] MINSTRETH_ADDR     = 12'hB82;
  localparam logic [CSR_ADDR_W-1:0] CYCLE_ADDR         = 12'hC00;
  localparam logic [CSR_ADDR_W-1:0] INSTRET_ADDR       = 12'hC02;
  localparam logic [CSR_ADDR_W-1:0] CYCLEH_ADDR        = 12'hC80;
  localparam logic [CSR_ADDR_W-1:0] INSTRETH_ADDR      = 12'hC82;
  // Information, read only
  localparam logic [CSR_ADDR_W-1:0] MVENDORID_ADDR     = 12'hF11;
  localparam logic [CSR_ADDR_W-1:0] MARCHID_ADDR       = 12'hF12;
  localparam logic [CSR_ADDR_W-1:0] MIMPID_ADDR        = 12'hF13;
  localparam logic [CSR_ADDR_W-1:0] MHARTID_ADDR       = 12'hF14;

  typedef enum logic [1:0] {U_MODE = 2'd0, M_MODE = 2'd3} priv_level_t;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_SET, OP_CLEAR} csr_op_t;

  typedef enum logic [4:0] {
    SEL_CONST, SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MCOUNTEREN, SEL_MCOUNTINHIBIT,
    SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
    SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH
  } csr_sel_t;

  typedef struct packed {
    logic [9:0]  wpri_31_22;
    logic        tw;
    logic [1:0]  wpri_20_19;      // tvm, mxr unused
    logic        sum;
    logic        mprv;
    logic [3:0]  wpri_16_13;      // xs, fs
    priv_level_t mpp;
    logic [1:0]  wpri_10_9;       // vs
    logic        spp;
    logic        mpie;
    logic        wpri_6;
    logic        spie;
    logic        wpri_4;
    logic        mie;
    logic        wpri_2;
    logic        sie;
    logic        wpri_0;
  } csr_mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;            // 0 direct, 1 vectored
  } csr_mtvec_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] reserved;
    logic        ir;
    logic        tm;
    logic        cy;
  } csr_counter_bits_t;

  typedef union packed {
    logic [XLEN-1:0]   raw;
    csr_mstatus_t      mstatus;
    csr_mtvec_t        mtvec;
    csr_counter_bits_t cnt;
  } csr_word_u;

  typedef struct packed {
    logic [CSR_ADDR_W-1:0] addr;
    csr_op_t               op;
    logic [XLEN-1:0]       wdata;
    priv_level_t           priv;
  } csr_req_t;

  typedef struct packed {
    csr_req_t req;
    csr_sel_t sel;
    logic     illegal;
  } csr_chk_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } csr_rsp_t;

  typedef struct packed {
    logic            valid;
    logic            is_instret;  // 0 cycle, 1 instret
    logic            high;        // Upper half
    logic [XLEN-1:0] value;
  } csr_cnt_wr_t;

  typedef struct packed {
    csr_mstatus_t    mstatus;
    csr_mtvec_t      mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mie;
  } csr_status_t;

endpackage

// ==== src/apb_csr_front.sv ====
/* APB completer front. One transfer at a time, always three wait states.
   PADDR[13:12] is the CSR op, PPROT[0] the privilege; PWRITE plays no part. */
module apb_csr_front (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      psel,
  input  logic                      penable,
  input  logic [13:0]               paddr,
  input  logic [csr_pkg::XLEN-1:0]  pwdata,
  input  logic [2:0]                pprot,
  output logic [csr_pkg::XLEN-1:0]  prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      req_valid,
  output csr_pkg::csr_req_t         req,
  input  logic                      rsp_valid,
  input  csr_pkg::csr_rsp_t         rsp
);

  logic busy;
  logic launch;

  // First access-phase cycle only
  assign launch = psel & penable & ~busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      req_valid <= launch;
      if (launch) begin
        busy <= 1'b1;
      end else if (rsp_valid) begin
        busy <= 1'b0;                     // Transfer completes this cycle
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (launch) begin
      req.addr  <= paddr[csr_pkg::CSR_ADDR_W-1:0];
      req.op    <= csr_pkg::csr_op_t'(paddr[13:12]);
      req.wdata <= pwdata;
      req.priv  <= pprot[0] ? csr_pkg::M_MODE : csr_pkg::U_MODE;
    end
  end

  // Response is a one-cycle pulse from the execute stage
  assign pready  = rsp_valid;
  assign prdata  = rsp.rdata;
  assign pslverr = rsp.err;

endmodule

// ==== src/csr_access_check.sv ====
/* Decode and legality stage. Every illegal-access rule lives here;
   later stages trust the illegal flag. */
module csr_access_check (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       req_valid,
  input  csr_pkg::csr_req_t          req,
  input  csr_pkg::csr_counter_bits_t mcounteren,
  output logic                       chk_valid,
  output csr_pkg::csr_chk_t          chk
);

  csr_pkg::csr_sel_t sel;
  logic known;
  logic user_ctr;       // User view of cycle or instret
  logic ctr_en;         // Matching mcounteren bit
  logic illegal;

  always_comb begin
    sel      = csr_pkg::SEL_CONST;
    known    = 1'b1;
    user_ctr = 1'b0;
    ctr_en   = 1'b1;
    case (req.addr)
      csr_pkg::MSTATUS_ADDR:       sel = csr_pkg::SEL_MSTATUS;
      csr_pkg::MIE_ADDR:           sel = csr_pkg::SEL_MIE;
      csr_pkg::MTVEC_ADDR:         sel = csr_pkg::SEL_MTVEC;
      csr_pkg::MCOUNTEREN_ADDR:    sel = csr_pkg::SEL_MCOUNTEREN;
      csr_pkg::MCOUNTINHIBIT_ADDR: sel = csr_pkg::SEL_MCOUNTINHIBIT;
      csr_pkg::MSCRATCH_ADDR:      sel = csr_pkg::SEL_MSCRATCH;
      csr_pkg::MEPC_ADDR:          sel = csr_pkg::SEL_MEPC;
      csr_pkg::MCAUSE_ADDR:        sel = csr_pkg::SEL_MCAUSE;
      csr_pkg::MTVAL_ADDR:         sel = csr_pkg::SEL_MTVAL;
      csr_pkg::MIP_ADDR:           sel = csr_pkg::SEL_MIP;
      csr_pkg::MCYCLE_ADDR:        sel = csr_pkg::SEL_MCYCLE;
      csr_pkg::MCYCLEH_ADDR:       sel = csr_pkg::SEL_MCYCLEH;
      csr_pkg::MINSTRET_ADDR:      sel = csr_pkg::SEL_MINSTRET;
      csr_pkg::MINSTRETH_ADDR:     sel = csr_pkg::SEL_MINSTRETH;
      csr_pkg::CYCLE_ADDR, csr_pkg::CYCLEH_ADDR: begin
        sel      = (req.addr == csr_pkg::CYCLE_ADDR) ? csr_pkg::SEL_MCYCLE : csr_pkg::SEL_MCYCLEH;
        user_ctr = 1'b1;
        ctr_en   = mcounteren.cy;
      end
      csr_pkg::INSTRET_ADDR, csr_pkg::INSTRETH_ADDR: begin
        sel      = (req.addr == csr_pkg::INSTRET_ADDR) ? csr_pkg::SEL_MINSTRET
                                                       : csr_pkg::SEL_MINSTRETH;
        user_ctr = 1'b1;
        ctr_en   = mcounteren.ir;
      end
      csr_pkg::MISA_ADDR, csr_pkg::MVENDORID_ADDR, csr_pkg::MARCHID_ADDR,
      csr_pkg::MIMPID_ADDR, csr_pkg::MHARTID_ADDR: sel = csr_pkg::SEL_CONST;
      default: known = 1'b0;
    endcase
  end

  assign illegal = ~known
                 | ((req.op != csr_pkg::OP_READ) && (req.addr[11:10] == 2'b11))  // Read-only space
                 | (req.addr[9:8] > req.priv)
                 | (user_ctr & (req.priv == csr_pkg::U_MODE) & ~ctr_en);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      chk_valid <= 1'b0;
    end else begin
      chk_valid <= req_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (req_valid) begin
      chk.req     <= req;
      chk.sel     <= sel;
      chk.illegal <= illegal;
    end
  end

endmodule

// ==== src/csr_counters.sv ====
/* 64-bit cycle and instret counters. A half write wins over counting in its cycle;
   the other half keeps its current value. */
module csr_counters (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       inst_ret,
  input  csr_pkg::csr_counter_bits_t mcountinhibit,
  input  csr_pkg::csr_cnt_wr_t       cnt_wr,
  output logic [63:0]                cycle,
  output logic [63:0]                instret
);

  logic wr_cycle;
  logic wr_instret;

  function automatic logic [63:0] next_count(input logic [63:0] cur, input logic hit,
                                             input logic inhibit, input logic [63:0] inc,
                                             input csr_pkg::csr_cnt_wr_t wr);
    logic [63:0] nxt;
    nxt = inhibit ? cur : cur + inc;
    if (hit) begin
      nxt = wr.high ? {wr.value, cur[31:0]} : {cur[63:32], wr.value};
    end
    return nxt;
  endfunction

  assign wr_cycle   = cnt_wr.valid & ~cnt_wr.is_instret;
  assign wr_instret = cnt_wr.valid & cnt_wr.is_instret;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle   <= '0;
      instret <= '0;
    end else begin
      cycle   <= next_count(cycle, wr_cycle, mcountinhibit.cy, 64'd1, cnt_wr);
      instret <= next_count(instret, wr_instret, mcountinhibit.ir,
                            {63'd0, inst_ret}, cnt_wr);   // At most one per cycle
    end
  end

endmodule

// ==== src/csr_regs.sv ====
/* Execute stage. Holds the machine CSRs, applies write/set/clear and WARL legalizing.
   Counter values live in csr_counters; writes to them leave as a cnt_wr pulse. */
module csr_regs (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       chk_valid,
  input  csr_pkg::csr_chk_t          chk,
  input  logic [63:0]                cycle,
  input  logic [63:0]                instret,
  output csr_pkg::csr_counter_bits_t mcounteren,
  output csr_pkg::csr_counter_bits_t mcountinhibit,
  output csr_pkg::csr_cnt_wr_t       cnt_wr,
  output csr_pkg::csr_status_t       status,
  output logic                       rsp_valid,
  output csr_pkg::csr_rsp_t          rsp
);

  csr_pkg::csr_mstatus_t      mstatus, mstatus_legal;
  csr_pkg::csr_mtvec_t        mtvec, mtvec_legal;
  csr_pkg::csr_counter_bits_t inhibit_legal;
  csr_pkg::csr_word_u         wr_word;
  logic [csr_pkg::XLEN-1:0]   mie, mip, mscratch, mepc, mcause, mtval;
  logic [csr_pkg::XLEN-1:0]   const_val, old_val, new_val;
  logic                       do_write;

  // Information CSRs, zero unless listed
  always_comb begin
    case (chk.req.addr)
      csr_pkg::MISA_ADDR:    const_val = csr_pkg::MISA_VALUE;
      csr_pkg::MHARTID_ADDR: const_val = csr_pkg::HART_ID;
      default:               const_val = '0;
    endcase
  end

  always_comb begin
    case (chk.sel)
      csr_pkg::SEL_MSTATUS:       old_val = mstatus;
      csr_pkg::SEL_MIE:           old_val = mie;
      csr_pkg::SEL_MTVEC:         old_val = mtvec;
      csr_pkg::SEL_MCOUNTEREN:    old_val = mcounteren;
      csr_pkg::SEL_MCOUNTINHIBIT: old_val = mcountinhibit;
      csr_pkg::SEL_MSCRATCH:      old_val = mscratch;
      csr_pkg::SEL_MEPC:          old_val = mepc;
      csr_pkg::SEL_MCAUSE:        old_val = mcause;
      csr_pkg::SEL_MTVAL:         old_val = mtval;
      csr_pkg::SEL_MIP:           old_val = mip;
      csr_pkg::SEL_MCYCLE:        old_val = cycle[31:0];
      csr_pkg::SEL_MCYCLEH:       old_val = cycle[63:32];
      csr_pkg::SEL_MINSTRET:      old_val = instret[31:0];
      csr_pkg::SEL_MINSTRETH:     old_val = instret[63:32];
      default:                    old_val = const_val;
    endcase
  end

  always_comb begin
    case (chk.req.op)
      csr_pkg::OP_WRITE: new_val = chk.req.wdata;
      csr_pkg::OP_SET:   new_val = old_val | chk.req.wdata;
      csr_pkg::OP_CLEAR: new_val = old_val & ~chk.req.wdata;
      default:           new_val = old_val;
    endcase
    wr_word.raw = new_val;

    mstatus_legal      = '0;      // Unimplemented fields read as zero
    mstatus_legal.sie  = wr_word.mstatus.sie;
    mstatus_legal.mie  = wr_word.mstatus.mie;
    mstatus_legal.spie = wr_word.mstatus.spie;
    mstatus_legal.mpie = wr_word.mstatus.mpie;
    mstatus_legal.spp  = wr_word.mstatus.spp;
    mstatus_legal.mprv = wr_word.mstatus.mprv;
    mstatus_legal.sum  = wr_word.mstatus.sum;
    mstatus_legal.tw   = wr_word.mstatus.tw;
    mstatus_legal.mpp  = (wr_word.mstatus.mpp == csr_pkg::M_MODE) ? csr_pkg::M_MODE
                                                                  : csr_pkg::U_MODE;
    mtvec_legal.base   = wr_word.mtvec.base;
    mtvec_legal.mode   = (wr_word.mtvec.mode > 2'b01) ? 2'b00 : wr_word.mtvec.mode;

    inhibit_legal      = '0;      // tm is hardwired off
    inhibit_legal.cy   = wr_word.cnt.cy;
    inhibit_legal.ir   = wr_word.cnt.ir;
  end

  assign do_write = chk_valid & ~chk.illegal & (chk.req.op != csr_pkg::OP_READ);

  // Counters take the write on the same edge as the CSRs
  always_comb begin
    cnt_wr.valid      = do_write & (chk.sel inside {csr_pkg::SEL_MCYCLE, csr_pkg::SEL_MCYCLEH,
                                                    csr_pkg::SEL_MINSTRET,
                                                    csr_pkg::SEL_MINSTRETH});
    cnt_wr.is_instret = (chk.sel == csr_pkg::SEL_MINSTRET) | (chk.sel == csr_pkg::SEL_MINSTRETH);
    cnt_wr.high       = (chk.sel == csr_pkg::SEL_MCYCLEH) | (chk.sel == csr_pkg::SEL_MINSTRETH);
    cnt_wr.value      = new_val;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= '{tw: 1'b1, mpp: csr_pkg::U_MODE, default: '0};
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1;
      mcountinhibit <= '0;
    end else if (do_write) begin
      case (chk.sel)
        csr_pkg::SEL_MSTATUS:       mstatus       <= mstatus_legal;
        csr_pkg::SEL_MTVEC:         mtvec         <= mtvec_legal;
        csr_pkg::SEL_MIE:           mie           <= new_val & csr_pkg::IRQ_MASK;
        csr_pkg::SEL_MIP:           mip           <= new_val & csr_pkg::IRQ_MASK;
        csr_pkg::SEL_MSCRATCH:      mscratch      <= new_val;
        csr_pkg::SEL_MEPC:          mepc          <= new_val;
        csr_pkg::SEL_MCAUSE:        mcause        <= new_val;
        csr_pkg::SEL_MTVAL:         mtval         <= new_val;
        csr_pkg::SEL_MCOUNTEREN:    mcounteren    <= wr_word.cnt;
        csr_pkg::SEL_MCOUNTINHIBIT: mcountinhibit <= inhibit_legal;
        default: ;                  // Counters and constants
      endcase
    end
  end

  // Old value back to the bus, zero on error
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rsp_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      rsp_valid <= chk_valid;
      if (chk_valid) begin
        rsp.rdata <= chk.illegal ? '0 : old_val;
        rsp.err   <= chk.illegal;
      end
    end
  end

  assign status.mstatus = mstatus;
  assign status.mtvec   = mtvec;
  assign status.mepc    = mepc;
  assign status.mie     = mie;

endmodule

// ==== src/csr_unit.sv ====
/* Machine-mode CSR unit behind an APB completer port.
   Front, check and execute stages, plus free-running counters. */
module csr_unit (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      psel,
  input  logic                      penable,
  input  logic [13:0]               paddr,
  input  logic [csr_pkg::XLEN-1:0]  pwdata,
  input  logic [2:0]                pprot,
  output logic [csr_pkg::XLEN-1:0]  prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      inst_ret,
  output csr_pkg::csr_status_t      status
);

  logic                       req_valid, chk_valid, rsp_valid;
  csr_pkg::csr_req_t          req;
  csr_pkg::csr_chk_t          chk;
  csr_pkg::csr_rsp_t          rsp;
  csr_pkg::csr_cnt_wr_t       cnt_wr;
  csr_pkg::csr_counter_bits_t mcounteren, mcountinhibit;
  logic [63:0]                cycle, instret;

  apb_csr_front i_front (
    .CLK, .nRST, .psel, .penable, .paddr, .pwdata, .pprot,
    .prdata, .pready, .pslverr, .req_valid, .req, .rsp_valid, .rsp
  );

  csr_access_check i_check (
    .CLK, .nRST, .req_valid, .req, .mcounteren, .chk_valid, .chk
  );

  csr_regs i_regs (
    .CLK, .nRST, .chk_valid, .chk, .cycle, .instret, .mcounteren,
    .mcountinhibit, .cnt_wr, .status, .rsp_valid, .rsp
  );

  csr_counters i_counters (
    .CLK, .nRST, .inst_ret, .mcountinhibit, .cnt_wr, .cycle, .instret
  );

endmodule

// ==== verification/csr_unit_tb.sv ====
/* Testbench for csr_unit. CSR state carries over from one test to the next,
   so the tests run in a fixed order. Each APB transfer must end within APB_TIMEOUT cycles. */
module csr_unit_tb;

  localparam int          APB_TIMEOUT  = 20;
  localparam logic [31:0] SEED         = 32'ha41c_e249;
  localparam logic [31:0] MSTATUS_BITS = 32'h0026_19AA;  // tw sum mprv mpp spp mpie spie mie sie
  localparam logic [31:0] IRQ_BITS     = 32'h0000_0888;  // msi, mti, mei
  localparam logic [31:0] MISA_RV32IU  = 32'h4010_0100;  // MXL=1, I and U

  logic                 CLK;
  logic                 nRST;
  logic                 psel;
  logic                 penable;
  logic [13:0]          paddr;
  logic [31:0]          pwdata;
  logic [2:0]           pprot;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 inst_ret;
  csr_pkg::csr_status_t status;

  logic [31:0] rng;
  int errors, checks, tests_run, tests_failed;

  csr_unit i_dut (
    .CLK, .nRST, .psel, .penable, .paddr, .pwdata, .pprot,
    .prdata, .pready, .pslverr, .inst_ret, .status
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    rng = xorshift(rng);
    v = rng;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rejected(input string what, input logic [31:0] rd, input logic err);
    check_eq({what, " PSLVERR"}, {31'd0, err}, 32'd1);
    check_eq({what, " PRDATA"}, rd, 32'd0);
  endtask

  // Setup phase, access phase, then wait for PREADY
  task automatic apb_access(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic machine,
                            output logic [31:0] rdata, output logic err);
    int waited;
    rdata = '0;
    err   = 1'b1;
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    paddr   <= {op, addr};
    pwdata  <= wdata;
    pprot   <= {2'b00, machine};
    @(posedge CLK);
    penable <= 1'b1;
    waited = 0;
    @(negedge CLK);
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (pready) begin
      rdata = prdata;
      err   = pslverr;
      check_eq("PREADY wait states", 32'(waited), 32'd3);   // Three-stage pipeline
    end else begin
      errors++;
      $display("APB transfer to CSR %h got no PREADY within %0d cycles", addr, APB_TIMEOUT);
    end
    @(posedge CLK);                       // Transfer completes on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic pulse_inst_ret(input int count);
    repeat (count) begin
      @(posedge CLK);
      inst_ret <= 1'b1;
      @(posedge CLK);
      inst_ret <= 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    logic [31:0] rd, x, model, scratch;
    logic [11:0] addr;
    logic        err;
    int          mark, n;
    nRST     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pprot    = '0;
    inst_ret = 1'b0;
    rng      = SEED;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    scratch = '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    mark = errors;
    for (int i = 0; i < 2; i++) begin
      addr  = (i == 0) ? csr_pkg::MSCRATCH_ADDR : csr_pkg::MEPC_ADDR;
      model = '0;                         // Reset value
      draw_random(x);
      apb_access(csr_pkg::OP_WRITE, addr, x, 1'b1, rd, err);
      check_eq("write old value", rd, model);
      model = x;
      draw_random(x);
      apb_access(csr_pkg::OP_SET, addr, x, 1'b1, rd, err);
      check_eq("set old value", rd, model);
      model = model | x;
      draw_random(x);
      apb_access(csr_pkg::OP_CLEAR, addr, x, 1'b1, rd, err);
      check_eq("clear old value", rd, model);
      model = model & ~x;
      apb_access(csr_pkg::OP_READ, addr, '0, 1'b1, rd, err);
      check_eq("read back", rd, model);
      check_eq("read PSLVERR", {31'd0, err}, 32'd0);
      if (i == 0) scratch = model;
      else check_eq("status.mepc", status.mepc, model);
    end
    finish_test("scratch operations", mark);

    mark = errors;
    for (int m = 2; m < 4; m++) begin
      draw_random(x);
      apb_access(csr_pkg::OP_WRITE, csr_pkg::MTVEC_ADDR, {x[31:2], 2'(m)}, 1'b1, rd, err);
      apb_access(csr_pkg::OP_READ, csr_pkg::MTVEC_ADDR, '0, 1'b1, rd, err);
      check_eq("mtvec mode", rd, {x[31:2], 2'b00});
      check_eq("status.mtvec", status.mtvec, {x[31:2], 2'b00});
    end
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MSTATUS_ADDR, 32'hFFFF_F7FF, 1'b1, rd, err);
    check_eq("mstatus reset value", rd, 32'h0020_0000);      // Only tw set
    apb_access(csr_pkg::OP_READ, csr_pkg::MSTATUS_ADDR, '0, 1'b1, rd, err);
    check_eq("mstatus with MPP 2", rd, MSTATUS_BITS & ~32'h0000_1800);
    check_eq("status.mstatus", status.mstatus, MSTATUS_BITS & ~32'h0000_1800);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MIE_ADDR, '1, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MIE_ADDR, '0, 1'b1, rd, err);
    check_eq("mie bits", rd, IRQ_BITS);
    check_eq("status.mie", status.mie, IRQ_BITS);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MIP_ADDR, '1, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MIP_ADDR, '0, 1'b1, rd, err);
    check_eq("mip bits", rd, IRQ_BITS);
    finish_test("write legalizing", mark);

    mark = errors;
    draw_random(x);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MSCRATCH_ADDR, x, 1'b0, rd, err);
    check_rejected("user mscratch write", rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MSCRATCH_ADDR, '0, 1'b1, rd, err);
    check_eq("mscratch after user write", rd, scratch);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MHARTID_ADDR, x, 1'b1, rd, err);
    check_rejected("mhartid write", rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MHARTID_ADDR, '0, 1'b1, rd, err);
    check_eq("mhartid after write", rd, csr_pkg::HART_ID);
    apb_access(csr_pkg::OP_WRITE, 12'h3A0, x, 1'b1, rd, err);   // Unused address
    check_rejected("unused address write", rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MSCRATCH_ADDR, '0, 1'b1, rd, err);
    check_eq("mscratch after unused write", rd, scratch);
    finish_test("illegal accesses", mark);

    mark = errors;
    apb_access(csr_pkg::OP_READ, csr_pkg::MHARTID_ADDR, '0, 1'b1, rd, err);
    check_eq("mhartid", rd, csr_pkg::HART_ID);
    apb_access(csr_pkg::OP_READ, csr_pkg::MISA_ADDR, '0, 1'b1, rd, err);
    check_eq("misa", rd, MISA_RV32IU);
    for (int a = 'hF11; a <= 'hF13; a++) begin    // mvendorid, marchid, mimpid
      apb_access(csr_pkg::OP_READ, 12'(a), '0, 1'b1, rd, err);
      check_eq("information CSR", rd, 32'd0);
      check_eq("information CSR PSLVERR", {31'd0, err}, 32'd0);
    end
    finish_test("information CSRs", mark);

    mark = errors;
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MCOUNTINHIBIT_ADDR, 32'h1, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MCYCLE_ADDR, '0, 1'b1, x, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MCYCLE_ADDR, '0, 1'b1, rd, err);
    check_eq("mcycle with cy inhibited", rd, x);
    draw_random(x);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MCYCLEH_ADDR, x, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::MCYCLEH_ADDR, '0, 1'b1, rd, err);
    check_eq("mcycleh write", rd, x);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MCOUNTINHIBIT_ADDR, 32'h5, 1'b1, rd, err);
    draw_random(x);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MINSTRET_ADDR, x, 1'b1, rd, err);
    pulse_inst_ret(3);
    apb_access(csr_pkg::OP_READ, csr_pkg::MINSTRET_ADDR, '0, 1'b1, rd, err);
    check_eq("minstret with ir inhibited", rd, x);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MCOUNTINHIBIT_ADDR, 32'h1, 1'b1, rd, err);
    draw_random(x);
    n = int'(rng[2:0]) + 1;
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MINSTRET_ADDR, x, 1'b1, rd, err);
    pulse_inst_ret(n);
    apb_access(csr_pkg::OP_READ, csr_pkg::MINSTRET_ADDR, '0, 1'b1, rd, err);
    check_eq("minstret after pulses", rd, x + n);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::MCOUNTINHIBIT_ADDR, 32'h0, 1'b1, rd, err);
    finish_test("counters", mark);

    mark = errors;
    draw_random(x);
    apb_access(csr_pkg::OP_CLEAR, csr_pkg::MCOUNTEREN_ADDR, 32'h1, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::CYCLE_ADDR, '0, 1'b0, rd, err);
    check_rejected("user cycle read, cy clear", rd, err);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::CYCLE_ADDR, x, 1'b0, rd, err);
    check_rejected("user cycle write, cy clear", rd, err);
    apb_access(csr_pkg::OP_SET, csr_pkg::MCOUNTEREN_ADDR, 32'h1, 1'b1, rd, err);
    apb_access(csr_pkg::OP_READ, csr_pkg::CYCLE_ADDR, '0, 1'b0, rd, err);
    check_eq("user cycle read, cy set", {31'd0, err}, 32'd0);
    apb_access(csr_pkg::OP_WRITE, csr_pkg::CYCLE_ADDR, x, 1'b0, rd, err);
    check_rejected("user cycle write, cy set", rd, err);
    finish_test("user counter gating", mark);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== csr_unit.f ====
src/csr_pkg.sv
src/apb_csr_front.sv
src/csr_access_check.sv
src/csr_counters.sv
src/csr_regs.sv
src/csr_unit.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
# Verilator flow for csr_unit: lint the RTL, build and run the testbench

VERILATOR ?= verilator
FILELIST  ?= csr_unit.f
TB_TOP    ?= csr_unit_tb
RTL_TOP   ?= csr_unit
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= all tests passed

RTL_SRCS := $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

# The run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
